// ==== common/mips_pkg.sv ====
// mips core shared definitions
// sizes, opcode and funct codes, alu operations, the instruction
// word layouts and the control and trace structs

`default_nettype none

package mips_pkg;

  // datapath and storage sizes
  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int dmem_words  = 256;
  localparam int dmem_addr_w = 8;

  // primary opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_slti  = 6'h0a;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_xori  = 6'h0e;
  localparam logic [5:0] op_lui   = 6'h0f;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // funct codes under op_rtype
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_nor = 6'h27;
  localparam logic [5:0] fn_slt = 6'h2a;

  // alu operation selected by decode
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_or  = 4'd3,
    alu_xor = 4'd4,
    alu_nor = 4'd5,
    alu_slt = 4'd6,
    alu_lui = 4'd7
  } alu_op_t;

  // register format
  typedef struct packed {
    logic [5:0]            opcode;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [4:0]            shamt;
    logic [5:0]            funct;
  } r_fields_t;

  // immediate format
  typedef struct packed {
    logic [5:0]            opcode;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [15:0]           imm16;
  } i_fields_t;

  // jump format, no jumps are executed by this core
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } j_fields_t;

  // one instruction word seen through any of its layouts
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } instr_t;

  typedef struct packed {
    logic    reg_write;
    logic    reg_dst_rd;
    logic    alu_src_imm;
    logic    imm_zero_ext;
    logic    mem_read;
    logic    mem_write;
    alu_op_t alu_op;
    logic    illegal;
  } ctrl_t;

  // register write seen at the top
  typedef struct packed {
    logic                  en;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } wb_trace_t;

  // store seen at the top, addr is a byte address
  typedef struct packed {
    logic            en;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } mem_trace_t;

  typedef struct packed {
    logic illegal;
    logic mem_fault;
  } err_t;

endpackage

`default_nettype wire

// ==== files.f ====
+incdir+tests
common/mips_pkg.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/data_memory.sv
rtl/mips_cpu.sv
tests/tb_mips_cpu.sv

// ==== rtl/control_unit.sv ====
// instruction decode
// turns opcode and funct into the control struct and flags
// any opcode or funct code the core does not implement

`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  mips_pkg::instr_t instruction,
  output mips_pkg::ctrl_t  ctrl
);

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = mips_pkg::alu_add;

    case (instruction.r.opcode)
      mips_pkg::op_rtype: begin
        ctrl.reg_write  = 1'b1;
        ctrl.reg_dst_rd = 1'b1;
        case (instruction.r.funct)
          mips_pkg::fn_add: ctrl.alu_op = mips_pkg::alu_add;
          mips_pkg::fn_sub: ctrl.alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and: ctrl.alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:  ctrl.alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor: ctrl.alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_nor: ctrl.alu_op = mips_pkg::alu_nor;
          mips_pkg::fn_slt: ctrl.alu_op = mips_pkg::alu_slt;
          default:          ctrl.illegal = 1'b1;
        endcase
      end
      mips_pkg::op_addi: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = mips_pkg::alu_add;
      end
      mips_pkg::op_slti: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = mips_pkg::alu_slt;
      end
      // logical immediates take a zero-extended operand
      mips_pkg::op_andi: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.alu_op       = mips_pkg::alu_and;
      end
      mips_pkg::op_ori: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.alu_op       = mips_pkg::alu_or;
      end
      mips_pkg::op_xori: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        ctrl.alu_op       = mips_pkg::alu_xor;
      end
      mips_pkg::op_lui: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = mips_pkg::alu_lui;
      end
      // loads and stores compute base plus offset
      mips_pkg::op_lw: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
      end
      mips_pkg::op_sw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // an illegal word must not change any state
    if (ctrl.illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/data_memory.sv ====
// data memory
// word array addressed by byte, asynchronous read and edge write
// flags misaligned and out of range accesses as faults

`timescale 1ns/1ps
`default_nettype none

module data_memory (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic [mips_pkg::xlen-1:0] addr,
  input  logic                      wr_en,
  input  logic [mips_pkg::xlen-1:0] wr_data,
  input  logic                      access,
  output logic [mips_pkg::xlen-1:0] rd_data,
  output logic                      fault
);

  logic [mips_pkg::xlen-1:0]        mem [mips_pkg::dmem_words];
  logic [mips_pkg::dmem_addr_w-1:0] word_idx;
  logic                             misaligned;
  logic                             out_of_range;

  assign word_idx   = addr[mips_pkg::dmem_addr_w+1:2];
  assign misaligned = addr[1:0] != 2'b00;

  // any bit above the word index means the address is past the array
  assign out_of_range = addr[mips_pkg::xlen-1:mips_pkg::dmem_addr_w+2] != '0;

  assign fault = access && (misaligned || out_of_range);

  assign rd_data = fault ? '0 : mem[word_idx];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mem <= '{default: '0};
    end else if (wr_en && !fault) begin
      mem[word_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
// execute stage
// extends the immediate, picks the second operand and runs the alu
// add and sub wrap without any overflow trap

`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic [mips_pkg::xlen-1:0] rs_data,
  input  logic [mips_pkg::xlen-1:0] rt_data,
  input  logic [15:0]               imm16,
  input  mips_pkg::ctrl_t           ctrl,
  output logic [mips_pkg::xlen-1:0] result
);

  logic [mips_pkg::xlen-1:0] imm_ext;
  logic [mips_pkg::xlen-1:0] operand_b;
  logic                      less_than;

  // zero extension only for the logical immediates
  always_comb begin
    if (ctrl.imm_zero_ext) begin
      imm_ext = {16'h0000, imm16};
    end else begin
      imm_ext = {{16{imm16[15]}}, imm16};
    end
  end

  always_comb begin
    if (ctrl.alu_src_imm) begin
      operand_b = imm_ext;
    end else begin
      operand_b = rt_data;
    end
  end

  // slt and slti compare as two's complement
  assign less_than = $signed(rs_data) < $signed(operand_b);

  always_comb begin
    case (ctrl.alu_op)
      mips_pkg::alu_add: begin
        result = rs_data + operand_b;
      end
      mips_pkg::alu_sub: begin
        result = rs_data - operand_b;
      end
      mips_pkg::alu_and: begin
        result = rs_data & operand_b;
      end
      mips_pkg::alu_or: begin
        result = rs_data | operand_b;
      end
      mips_pkg::alu_xor: begin
        result = rs_data ^ operand_b;
      end
      mips_pkg::alu_nor: begin
        result = ~(rs_data | operand_b);
      end
      mips_pkg::alu_slt: begin
        result = {{(mips_pkg::xlen-1){1'b0}}, less_than};
      end
      // immediate goes to the upper half, lower half cleared
      mips_pkg::alu_lui: begin
        result = {imm16, 16'h0000};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mips_cpu.sv ====
// single-cycle mips core
// decode, register read, execute and memory access in one cycle,
// register and memory writes commit at the closing clock edge

`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  mips_pkg::instr_t     instruction,
  output mips_pkg::wb_trace_t  wb,
  output mips_pkg::mem_trace_t mem_wr,
  output mips_pkg::err_t       err
);

  mips_pkg::ctrl_t                 ctrl;
  logic [mips_pkg::reg_addr_w-1:0] wr_addr;
  logic [mips_pkg::xlen-1:0]       rs_data;
  logic [mips_pkg::xlen-1:0]       rt_data;
  logic [mips_pkg::xlen-1:0]       result;
  logic [mips_pkg::xlen-1:0]       load_data;
  logic [mips_pkg::xlen-1:0]       wb_data;
  logic                            fault;
  logic                            active;
  logic                            commit;
  logic                            reg_wr_en;
  logic                            mem_wr_en;

  control_unit u_control_unit (
    .instruction (instruction),
    .ctrl        (ctrl)
  );

  // rd for register format, rt for immediates and loads
  assign wr_addr = ctrl.reg_dst_rd ? instruction.r.rd : instruction.r.rt;

  reg_file u_reg_file (
    .clock   (clock),
    .rst_n   (rst_n),
    .rs_addr (instruction.r.rs),
    .rt_addr (instruction.r.rt),
    .wr_addr (wr_addr),
    .wr_en   (reg_wr_en),
    .wr_data (wb_data),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  execute_unit u_execute_unit (
    .rs_data (rs_data),
    .rt_data (rt_data),
    .imm16   (instruction.i.imm16),
    .ctrl    (ctrl),
    .result  (result)
  );

  data_memory u_data_memory (
    .clock   (clock),
    .rst_n   (rst_n),
    .addr    (result),
    .wr_en   (mem_wr_en),
    .wr_data (rt_data),
    .access  (ctrl.mem_read || ctrl.mem_write),
    .rd_data (load_data),
    .fault   (fault)
  );

  assign wb_data = ctrl.mem_read ? load_data : result;

  // reset holds off every write and error pulse
  assign active = instr_valid && rst_n;

  // nothing commits for idle cycles, illegal words or faulting accesses
  assign commit    = active && !ctrl.illegal && !fault;
  assign reg_wr_en = commit && ctrl.reg_write;
  assign mem_wr_en = commit && ctrl.mem_write;

  assign wb.en   = reg_wr_en;
  assign wb.addr = wr_addr;
  assign wb.data = wb_data;

  assign mem_wr.en   = mem_wr_en;
  assign mem_wr.addr = result;
  assign mem_wr.data = rt_data;

  assign err.illegal   = active && ctrl.illegal;
  assign err.mem_fault = active && fault;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// register file
// 32 x 32-bit, two asynchronous read ports and one write port
// register 0 is hardwired to zero

`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
  input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
  input  logic [mips_pkg::reg_addr_w-1:0] wr_addr,
  input  logic                            wr_en,
  input  logic [mips_pkg::xlen-1:0]       wr_data,
  output logic [mips_pkg::xlen-1:0]       rs_data,
  output logic [mips_pkg::xlen-1:0]       rt_data
);

  logic [mips_pkg::xlen-1:0] regs [2**mips_pkg::reg_addr_w];

  // write lands at the edge, so readers see it from the next cycle
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // combinational reads
  always_comb begin
    if (rs_addr == '0) begin
      rs_data = '0;
    end else begin
      rs_data = regs[rs_addr];
    end
  end

  always_comb begin
    if (rt_addr == '0) begin
      rt_data = '0;
    end else begin
      rt_data = regs[rt_addr];
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the mips core testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_mips_cpu -f files.f \
    -Mdir obj_dir -o tb_mips_cpu_sim \
  && ./obj_dir/tb_mips_cpu_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "^TESTS PASSED$" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== tests/mips_ref_model.svh ====
// reference model for the mips core testbench
// keeps its own registers and data memory and predicts the
// trace and error outputs of one cycle from the instruction rules

`ifndef mips_ref_model_svh
`define mips_ref_model_svh

logic [mips_pkg::xlen-1:0] ref_regs [32];
logic [mips_pkg::xlen-1:0] ref_mem [mips_pkg::dmem_words];

// prediction for the cycle in flight
mips_pkg::wb_trace_t  exp_wb;
mips_pkg::mem_trace_t exp_mem;
mips_pkg::err_t       exp_err;

task automatic clear_model();
  ref_regs = '{default: '0};
  ref_mem  = '{default: '0};
endtask

// register 0 always reads as zero
function automatic logic [31:0] read_reg(input logic [4:0] idx);
  return (idx == 5'd0) ? 32'h0000_0000 : ref_regs[idx];
endfunction

task automatic predict(input logic valid, input mips_pkg::instr_t word);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] simm;
  logic [31:0] zimm;
  logic [31:0] value;
  logic [4:0]  dest;
  logic        legal;
  logic        fault;
  a     = read_reg(word.r.rs);
  b     = read_reg(word.r.rt);
  simm  = {{16{word.i.imm16[15]}}, word.i.imm16};
  zimm  = {16'h0000, word.i.imm16};
  dest  = word.i.rt;
  legal = 1'b1;
  fault = 1'b0;
  value = '0;
  case (word.r.opcode)
    mips_pkg::op_rtype: begin
      dest = word.r.rd;
      case (word.r.funct)
        mips_pkg::fn_add: value = a + b;
        mips_pkg::fn_sub: value = a - b;
        mips_pkg::fn_and: value = a & b;
        mips_pkg::fn_or:  value = a | b;
        mips_pkg::fn_xor: value = a ^ b;
        mips_pkg::fn_nor: value = ~(a | b);
        mips_pkg::fn_slt: value = {31'h0, $signed(a) < $signed(b)};
        default:          legal = 1'b0;
      endcase
    end
    mips_pkg::op_addi: value = a + simm;
    mips_pkg::op_slti: value = {31'h0, $signed(a) < $signed(simm)};
    mips_pkg::op_andi: value = a & zimm;
    mips_pkg::op_ori:  value = a | zimm;
    mips_pkg::op_xori: value = a ^ zimm;
    mips_pkg::op_lui:  value = {word.i.imm16, 16'h0000};
    mips_pkg::op_lw, mips_pkg::op_sw: begin
      value = a + simm;
      // must be word aligned and inside the 1 KiB array
      fault = (value[1:0] != 2'b00) || (value >= 32'(mips_pkg::dmem_words * 4));
    end
    default: legal = 1'b0;
  endcase
  exp_err.illegal   = valid && !legal;
  exp_err.mem_fault = valid && legal && fault;
  exp_mem.en        = valid && legal && !fault && (word.r.opcode == mips_pkg::op_sw);
  exp_mem.addr      = value;
  exp_mem.data      = b;
  exp_wb.en         = valid && legal && !fault && (word.r.opcode != mips_pkg::op_sw);
  exp_wb.addr       = dest;
  if (word.r.opcode == mips_pkg::op_lw) begin
    exp_wb.data = ref_mem[value[mips_pkg::dmem_addr_w+1:2]];
  end else begin
    exp_wb.data = value;
  end
endtask

// state changes land at the clock edge that closes the cycle
task automatic commit_model();
  if (exp_wb.en && (exp_wb.addr != 5'd0)) begin
    ref_regs[exp_wb.addr] = exp_wb.data;
  end
  if (exp_mem.en) begin
    ref_mem[exp_mem.addr[mips_pkg::dmem_addr_w+1:2]] = exp_mem.data;
  end
endtask

`endif

// ==== tests/tb_mips_cpu.sv ====
// testbench for the single-cycle mips core
// random instruction stream, checked every cycle against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int setup_cycles = 7;
  localparam int num_instr    = 3000;
  localparam int timeout_ns   = (reset_cycles + setup_cycles + num_instr + 50) * clk_period;

  logic                 clock;
  logic                 rst_n;
  logic                 instr_valid;
  mips_pkg::instr_t     instruction;
  mips_pkg::wb_trace_t  wb;
  mips_pkg::mem_trace_t mem_wr;
  mips_pkg::err_t       err;

  int error_count;
  int cycle_count;

  `include "mips_ref_model.svh"

  mips_cpu u_mips_cpu (
    .clock       (clock),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instruction (instruction),
    .wb          (wb),
    .mem_wr      (mem_wr),
    .err         (err)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(clk_period / 2) clock = ~clock;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_count++;
    $display("Mismatch %s at %0t ns: got 0x%h expected 0x%h", name, $time, got, exp);
  endtask

  // address and data only matter while the matching enable is expected
  task automatic check_outputs();
    if (err.illegal !== exp_err.illegal) begin
      report_mismatch("err.illegal", 32'(err.illegal), 32'(exp_err.illegal));
    end
    if (err.mem_fault !== exp_err.mem_fault) begin
      report_mismatch("err.mem_fault", 32'(err.mem_fault), 32'(exp_err.mem_fault));
    end
    if (wb.en !== exp_wb.en) begin
      report_mismatch("wb.en", 32'(wb.en), 32'(exp_wb.en));
    end
    if (exp_wb.en && (wb.addr !== exp_wb.addr)) begin
      report_mismatch("wb.addr", 32'(wb.addr), 32'(exp_wb.addr));
    end
    if (exp_wb.en && (wb.data !== exp_wb.data)) begin
      report_mismatch("wb.data", wb.data, exp_wb.data);
    end
    if (mem_wr.en !== exp_mem.en) begin
      report_mismatch("mem_wr.en", 32'(mem_wr.en), 32'(exp_mem.en));
    end
    if (exp_mem.en && (mem_wr.addr !== exp_mem.addr)) begin
      report_mismatch("mem_wr.addr", mem_wr.addr, exp_mem.addr);
    end
    if (exp_mem.en && (mem_wr.data !== exp_mem.data)) begin
      report_mismatch("mem_wr.data", mem_wr.data, exp_mem.data);
    end
  endtask

  // drive after the edge, check at mid cycle, then commit the model
  task automatic run_cycle(input logic rst_level, input logic valid,
                           input mips_pkg::instr_t word);
    @(posedge clock);
    #2;
    rst_n       = rst_level;
    instr_valid = valid;
    instruction = word;
    if (!rst_level) begin
      clear_model();
    end
    // while reset is held the core must stay quiet whatever it is fed
    predict(valid && rst_level, word);
    @(negedge clock);
    check_outputs();
    commit_model();
    cycle_count++;
  endtask

  // low registers most of the time so results get reused
  function automatic logic [4:0] pick_reg();
    if ($urandom_range(0, 9) < 9) begin
      return 5'($urandom_range(0, 7));
    end
    return 5'($urandom_range(0, 31));
  endfunction

  function automatic logic known_opcode(input logic [5:0] op);
    return op inside {mips_pkg::op_rtype, mips_pkg::op_addi, mips_pkg::op_slti,
                      mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori,
                      mips_pkg::op_lui, mips_pkg::op_lw, mips_pkg::op_sw};
  endfunction

  function automatic logic known_funct(input logic [5:0] fn);
    return fn inside {mips_pkg::fn_add, mips_pkg::fn_sub, mips_pkg::fn_and,
                      mips_pkg::fn_or, mips_pkg::fn_xor, mips_pkg::fn_nor,
                      mips_pkg::fn_slt};
  endfunction

  function automatic logic [5:0] alu_funct(input int n);
    case (n)
      0:       return mips_pkg::fn_add;
      1:       return mips_pkg::fn_sub;
      2:       return mips_pkg::fn_and;
      3:       return mips_pkg::fn_or;
      4:       return mips_pkg::fn_xor;
      5:       return mips_pkg::fn_nor;
      default: return mips_pkg::fn_slt;
    endcase
  endfunction

  function automatic logic [5:0] alu_immediate_op(input int n);
    case (n)
      0:       return mips_pkg::op_addi;
      1:       return mips_pkg::op_slti;
      2:       return mips_pkg::op_andi;
      3:       return mips_pkg::op_ori;
      4:       return mips_pkg::op_xori;
      default: return mips_pkg::op_lui;
    endcase
  endfunction

  // offset chosen against the base so most accesses land in a small window
  task automatic memory_instruction(inout mips_pkg::instr_t word);
    logic [31:0] target;
    logic [31:0] offset;
    int          kind;
    kind          = int'($urandom_range(0, 9));
    word.i.opcode = $urandom_range(0, 1) ? mips_pkg::op_lw : mips_pkg::op_sw;
    target        = {24'h0, 6'($urandom_range(0, 63)), 2'b00};
    if (kind == 0) begin
      target[1:0] = 2'($urandom_range(1, 3));
    end else if (kind == 1) begin
      target = 32'h0000_0400 + {20'h0, 10'($urandom), 2'b00};
    end
    offset = target - read_reg(word.i.rs);
    // base too far away for a 16-bit offset
    if ((offset[31:15] != 17'h0) && (offset[31:15] != 17'h1_ffff)) begin
      word.i.rs = 5'd0;
      offset    = target;
    end
    // kind 2 keeps the raw random offset
    if (kind != 2) begin
      word.i.imm16 = offset[15:0];
    end
  endtask

  task automatic random_instruction(output logic valid, output mips_pkg::instr_t word);
    int pick;
    pick      = int'($urandom_range(0, 99));
    valid     = 1'b1;
    word      = mips_pkg::instr_t'($urandom);
    word.r.rs = pick_reg();
    word.r.rt = pick_reg();
    word.r.rd = pick_reg();
    if (pick < 6) begin
      valid = 1'b0;
    end else if (pick < 9) begin
      while (known_opcode(word.r.opcode)) begin
        word.r.opcode = 6'($urandom);
      end
    end else if (pick < 12) begin
      word.r.opcode = mips_pkg::op_rtype;
      while (known_funct(word.r.funct)) begin
        word.r.funct = 6'($urandom);
      end
    end else if (pick < 35) begin
      memory_instruction(word);
    end else if (pick < 65) begin
      word.r.opcode = mips_pkg::op_rtype;
      word.r.funct  = alu_funct(int'($urandom_range(0, 6)));
    end else begin
      word.i.opcode = alu_immediate_op(int'($urandom_range(0, 5)));
    end
  endtask

  initial begin
    mips_pkg::instr_t word;
    logic             valid;
    void'($urandom(32'hc633_5c10));
    error_count = 0;
    cycle_count = 0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instruction = '0;
    clear_model();
    // valid instructions during reset must not write or flag anything
    repeat (reset_cycles) begin
      random_instruction(valid, word);
      run_cycle(1'b0, 1'b1, word);
    end
    // r1 to r7 start at small aligned values used as load and store bases
    for (int n = 1; n <= setup_cycles; n++) begin
      word          = '0;
      word.i.opcode = mips_pkg::op_addi;
      word.i.rt     = 5'(n);
      word.i.imm16  = 16'(n * 32);
      run_cycle(1'b1, 1'b1, word);
    end
    repeat (num_instr) begin
      random_instruction(valid, word);
      run_cycle(1'b1, valid, word);
    end
    $display("summary: %0d cycles checked, %0d errors", cycle_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog: run did not finish within %0d ns", timeout_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
